// ==== tb/fpu_patterns.hex ====
// op fwd_a fwd_b fpcsr a b exp_res exp_exc_valid exp_exc_code
// one operation per line in issue order, a forward bit takes the result of the line above
0 0 0 03 0123456789abcdef ff00ff00f0f0f0f0 0100450080a0c0e0 0 0
1 0 0 03 0123456789abcdef ff00ff00f0f0f0f0 ff23ff67f9fbfdff 0 0
2 0 0 03 0123456789abcdef ff00ff00f0f0f0f0 fe23ba67795b3d1f 0 0
3 0 0 03 0123456789abcdef ff00ff00f0f0f0f0 00230067090b0d0f 0 0
4 0 0 03 0123456789abcdef 0000000000000000 89abcdef01234567 0 0
2 1 0 03 0000000000000000 ffffffff00000000 7654321001234567 0 0
5 1 0 03 0000000000000000 0000000000000000 0123456701234567 0 0
1 0 1 03 f000000000000000 0000000000000000 f123456701234567 0 0
3 1 1 03 0000000000000000 0000000000000000 0000000000000000 0 0
8 0 0 03 3ff0000000000000 3ff0000000000000 ffffffffffffffff 0 0
8 0 0 03 0000000000000000 8000000000000000 ffffffffffffffff 0 0
9 0 0 03 3ff0000000000000 4000000000000000 ffffffffffffffff 0 0
9 0 0 03 c000000000000000 bff0000000000000 ffffffffffffffff 0 0
9 0 0 03 8000000000000000 0000000000000000 0000000000000000 0 0
a 0 0 03 3f80000040000000 3f80000000000000 ffffffff00000000 0 0
b 0 0 03 40000000bf800000 3f8000003f800000 00000000ffffffff 0 0
9 0 0 03 7ff8000000000000 3ff0000000000000 0000000000000000 1 1
8 0 0 03 7ff8000000000000 7ff8000000000000 0000000000000000 0 0
8 0 0 03 7ff0000000000001 3ff0000000000000 0000000000000000 1 1
8 0 0 03 0000000000000001 0000000000000001 ffffffffffffffff 1 2
b 0 0 03 7fc0000000000001 3f8000003f800000 00000000ffffffff 1 1
b 0 0 fe 7fc0000000000001 3f8000003f800000 00000000ffffffff 1 2
a 0 0 01 0000000100000000 0000000100000000 ffffffffffffffff 0 0
9 0 0 00 3ff0000000000000 7ff8000000000000 0000000000000000 0 0
7 0 0 03 0123456789abcdef ff00ff00f0f0f0f0 0000000000000000 0 0

// ==== list.f ====
hdl/fpu_pkg.sv
hdl/fpu_op_decode.sv
hdl/fpu_operand_sel.sv
hdl/fpu_perm_logic.sv
hdl/fpu_compare.sv
hdl/fpu_writeback.sv
hdl/fpu_unit.sv
tb/fpu_unit_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps
TOP       = fpu_unit_tb
FILELIST  = list.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== tb/fpu_unit_tb.sv ====
// testbench for the packed FP side unit driven from tb/fpu_patterns.hex
// nine hex fields per pattern line
// an all-ones first field marks the end of the patterns
// pass one issues every pattern two cycles apart so that forwarding sees the line above
// pass two issues the non-forwarding patterns back to back

module fpu_unit_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import fpu_pkg::*;

  localparam int MAX_PAT = 64;
  localparam int FIELDS  = 9;

  logic                clk;
  logic                rst;
  logic                in_valid;
  op_t                 op;
  fp_word_u            a;
  fp_word_u            b;
  logic                fwd_a;
  logic                fwd_b;
  logic [FPCSR_W-1:0]  fpcsr;
  fp_word_u            res;
  logic                res_valid;
  logic                exc_valid;
  exc_code_t           exc_code;

  logic [63:0] pat_mem [0:MAX_PAT*FIELDS-1];
  int          num_pat;
  int          burst_idx[$];
  int          cycle_count = 0;
  int          cycle_limit = 0;

  fpu_unit fpu_unit_i (
    .clk(clk), .rst(rst), .in_valid(in_valid), .op(op), .a(a), .b(b),
    .fwd_a(fwd_a), .fwd_b(fwd_b), .fpcsr(fpcsr),
    .res(res), .res_valid(res_valid), .exc_valid(exc_valid), .exc_code(exc_code)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // limit is set once the pattern count is known
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: run did not end within %0d cycles", cycle_limit);
      $display("TESTS FAILED");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic report_failure(string msg);
    $display("FAIL %0t ns: %s", $time, msg);
    $display("TESTS FAILED");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic check_word(fp_word_u got, fp_word_u exp, string what);
    if (got !== exp)
      report_failure($sformatf("%s: res %h, expected %h", what, got, exp));
  endtask

  task automatic check_valid(logic got, logic exp, string what);
    if (got !== exp)
      report_failure($sformatf("%s: res_valid %b, expected %b", what, got, exp));
  endtask

  task automatic check_exc(logic got_valid, exc_code_t got_code, logic exp_valid,
                           exc_code_t exp_code, string what);
    if (got_valid !== exp_valid || got_code !== exp_code)
      report_failure($sformatf("%s: exception %b/%0d, expected %b/%0d", what,
                               got_valid, got_code, exp_valid, exp_code));
  endtask

  task automatic drive_idle();
    in_valid = 1'b0;
    op       = OP_AND;
    a        = '0;
    b        = '0;
    fwd_a    = 1'b0;
    fwd_b    = 1'b0;
    fpcsr    = '0;
  endtask

  task automatic drive_pattern(int p);
    int base;
    base     = p * FIELDS;
    in_valid = 1'b1;
    op       = pat_mem[base][3:0];
    fwd_a    = pat_mem[base+1][0];
    fwd_b    = pat_mem[base+2][0];
    fpcsr    = pat_mem[base+3][FPCSR_W-1:0];
    a        = pat_mem[base+4];
    b        = pat_mem[base+5];
  endtask

  task automatic check_pattern(int p, string pass_name);
    int    base;
    string what;
    base = p * FIELDS;
    what = $sformatf("%s pattern %0d", pass_name, p);
    check_valid(res_valid, 1'b1, what);
    check_word(res, pat_mem[base+6], what);
    check_exc(exc_valid, exc_code, pat_mem[base+7][0], pat_mem[base+8][1:0], what);
  endtask

  initial begin
    drive_idle();
    rst = 1'b1;
    for (int i = 0; i < MAX_PAT * FIELDS; i++) begin
      pat_mem[i] = '1;
    end
    $readmemh("tb/fpu_patterns.hex", pat_mem);
    num_pat = 0;
    while (num_pat < MAX_PAT && pat_mem[num_pat*FIELDS] != '1) begin
      num_pat++;
    end
    if (num_pat == 0) begin
      $display("no patterns could be read from tb/fpu_patterns.hex");
      $display("TESTS FAILED");
      $fatal(1, "empty pattern file");
    end
    cycle_limit = 4 * num_pat + 20;

    repeat (3) @(negedge clk);
    rst = 1'b0;
    // nothing may come out before the first issue
    repeat (2) begin
      @(negedge clk);
      check_valid(res_valid, 1'b0, "idle after reset");
      check_exc(exc_valid, exc_code, 1'b0, EXC_NONE, "idle after reset");
      check_word(res, '0, "idle after reset");
    end

    // spaced issue with the result due one edge after its issue edge
    @(negedge clk);
    drive_pattern(0);
    for (int p = 0; p < num_pat; p++) begin
      @(negedge clk);
      drive_idle();
      check_valid(res_valid, 1'b0, $sformatf("gap before result %0d", p));
      @(negedge clk);
      check_pattern(p, "spaced");
      if (p + 1 < num_pat)
        drive_pattern(p + 1);
    end

    for (int p = 0; p < num_pat; p++) begin
      if (pat_mem[p*FIELDS+1] == 64'd0 && pat_mem[p*FIELDS+2] == 64'd0)
        burst_idx.push_back(p);
    end
    // back to back issue with each result two falling edges after its drive
    for (int t = 0; t < burst_idx.size() + 2; t++) begin
      @(negedge clk);
      if (t >= 2)
        check_pattern(burst_idx[t-2], "burst");
      if (t < burst_idx.size())
        drive_pattern(burst_idx[t]);
      else
        drive_idle();
    end
    @(negedge clk);
    check_valid(res_valid, 1'b0, "after burst");

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== hdl/fpu_unit.sv ====
// packed FP side unit, logic/permute and compare lanes
// issue on in_valid, result and exception one cycle later
// no back-pressure, results leave in issue order

module fpu_unit (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        in_valid,
  input  fpu_pkg::op_t                op,
  input  fpu_pkg::fp_word_u           a,
  input  fpu_pkg::fp_word_u           b,
  input  logic                        fwd_a,
  input  logic                        fwd_b,
  input  logic [fpu_pkg::FPCSR_W-1:0] fpcsr,
  output fpu_pkg::fp_word_u           res,
  output logic                        res_valid,
  output logic                        exc_valid,
  output fpu_pkg::exc_code_t          exc_code
);

  logic              issue_valid;
  fpu_pkg::lane_t    lane;
  fpu_pkg::op_t      perm_mode;
  logic              cmp_lt;
  logic              cmp_paired;
  logic [1:0]        exc_en;
  fpu_pkg::fp_word_u opa, opb;
  fpu_pkg::fp_word_u perm_res, cmp_res;
  logic [1:0]        cmp_raise;

  fpu_op_decode fpu_op_decode_i (
    .clk(clk), .rst(rst), .in_valid(in_valid), .op(op), .fpcsr(fpcsr),
    .issue_valid(issue_valid), .lane(lane), .perm_mode(perm_mode),
    .cmp_lt(cmp_lt), .cmp_paired(cmp_paired), .exc_en(exc_en)
  );

  // res loops back for forwarding
  fpu_operand_sel fpu_operand_sel_i (
    .clk(clk), .rst(rst), .in_valid(in_valid), .a(a), .b(b), .res(res),
    .fwd_a(fwd_a), .fwd_b(fwd_b), .opa(opa), .opb(opb)
  );

  fpu_perm_logic fpu_perm_logic_i (
    .opa(opa), .opb(opb), .perm_mode(perm_mode), .perm_res(perm_res)
  );

  fpu_compare fpu_compare_i (
    .opa(opa), .opb(opb), .cmp_lt(cmp_lt), .cmp_paired(cmp_paired),
    .cmp_res(cmp_res), .cmp_raise(cmp_raise)
  );

  fpu_writeback fpu_writeback_i (
    .clk(clk), .rst(rst), .issue_valid(issue_valid), .lane(lane),
    .perm_res(perm_res), .cmp_res(cmp_res), .cmp_raise(cmp_raise), .exc_en(exc_en),
    .res(res), .res_valid(res_valid), .exc_valid(exc_valid), .exc_code(exc_code)
  );

endmodule

// ==== hdl/fpu_writeback.sv ====
// result register and exception report, one cycle after issue
// raised bits count only for the compare lane
// result is written even when the exception is reported

module fpu_writeback (
  input  logic                clk,
  input  logic                rst,
  input  logic                issue_valid,
  input  fpu_pkg::lane_t      lane,
  input  fpu_pkg::fp_word_u   perm_res,
  input  fpu_pkg::fp_word_u   cmp_res,
  input  logic [1:0]          cmp_raise,
  input  logic [1:0]          exc_en,
  output fpu_pkg::fp_word_u   res,
  output logic                res_valid,
  output logic                exc_valid,
  output fpu_pkg::exc_code_t  exc_code
);
  import fpu_pkg::*;

  fp_word_u  sel_res;
  logic [1:0] masked;

  assign sel_res = (lane == LANE_PERM) ? perm_res :
                   (lane == LANE_CMP)  ? cmp_res  : fp_word_u'('0);
  assign masked  = (lane == LANE_CMP) ? (cmp_raise & exc_en) : 2'b00;

  always_ff @(posedge clk) begin
    if (rst) begin
      res       <= '0;
      res_valid <= 1'b0;
      exc_valid <= 1'b0;
      exc_code  <= EXC_NONE;
    end else begin
      res_valid <= issue_valid;
      exc_valid <= issue_valid && (|masked);
      if (issue_valid) begin
        res <= sel_res;
        // invalid wins over denormal
        exc_code <= masked[0] ? EXC_INVALID :
                    masked[1] ? EXC_DENORM  : EXC_NONE;
      end
    end
  end

endmodule

// ==== hdl/fpu_compare.sv ====
// double or paired-single compare, all-ones mask for a true element
// NaN makes an element false, +0 and -0 compare equal
// raise bit 0 invalid, bit 1 denormal input

module fpu_compare (
  input  fpu_pkg::fp_word_u opa,
  input  fpu_pkg::fp_word_u opb,
  input  logic             cmp_lt,
  input  logic             cmp_paired,
  output fpu_pkg::fp_word_u cmp_res,
  output logic [1:0]       cmp_raise
);
  import fpu_pkg::*;

  logic [1:0][62:0] a_mag, b_mag;
  logic [1:0]       a_sgn, b_sgn;
  logic [1:0]       any_nan, any_snan, any_den, hit;
  logic [62:0]      inf_mag, min_norm;
  int               qbit;

  function automatic logic fp_eq(logic [62:0] ma, logic sa, logic [62:0] mb, logic sb);
    return (ma == '0 && mb == '0) || (sa == sb && ma == mb);
  endfunction

  function automatic logic fp_lt(logic [62:0] ma, logic sa, logic [62:0] mb, logic sb);
    if (ma == '0 && mb == '0) return 1'b0;
    if (sa != sb) return sa;
    // same sign, negative flips the magnitude order
    return sa ? (ma > mb) : (ma < mb);
  endfunction

  always_comb begin
    inf_mag  = cmp_paired ? SGL_INF_MAG : DBL_INF_MAG;
    min_norm = cmp_paired ? SGL_MIN_NORM : DBL_MIN_NORM;
    qbit     = cmp_paired ? SGL_QBIT : DBL_QBIT;
    for (int i = 0; i < 2; i++) begin
      a_sgn[i] = 1'b0;
      b_sgn[i] = 1'b0;
      a_mag[i] = '0;
      b_mag[i] = '0;
      if (cmp_paired) begin
        a_sgn[i] = opa.s[i].sign;
        b_sgn[i] = opb.s[i].sign;
        a_mag[i] = {32'b0, opa.s[i].exp, opa.s[i].man};
        b_mag[i] = {32'b0, opb.s[i].exp, opb.s[i].man};
      end else if (i == 0) begin
        a_sgn[i] = opa.d.sign;
        b_sgn[i] = opb.d.sign;
        a_mag[i] = {opa.d.exp, opa.d.man};
        b_mag[i] = {opb.d.exp, opb.d.man};
      end
      // upper element of a double compare stays all zero, so no flags
      any_nan[i]  = (a_mag[i] > inf_mag) || (b_mag[i] > inf_mag);
      any_snan[i] = ((a_mag[i] > inf_mag) && !a_mag[i][qbit]) ||
                    ((b_mag[i] > inf_mag) && !b_mag[i][qbit]);
      any_den[i]  = (a_mag[i] != '0 && a_mag[i] < min_norm) ||
                    (b_mag[i] != '0 && b_mag[i] < min_norm);
      hit[i] = !any_nan[i] && (cmp_lt ? fp_lt(a_mag[i], a_sgn[i], b_mag[i], b_sgn[i]) :
                                        fp_eq(a_mag[i], a_sgn[i], b_mag[i], b_sgn[i]));
    end
  end

  always_comb begin
    if (cmp_paired) begin
      cmp_res.s[0] = sgl_t'({32{hit[0]}});
      cmp_res.s[1] = sgl_t'({32{hit[1]}});
    end else begin
      cmp_res.d = dbl_t'({64{hit[0]}});
    end
  end

  // quiet NaN only trips invalid on the ordered compares
  assign cmp_raise[0] = cmp_lt ? |any_nan : |any_snan;
  assign cmp_raise[1] = |any_den;

endmodule

// ==== hdl/fpu_perm_logic.sv ====
// bitwise logic on the full word, swap and duplicate on the single view
// codes that are not logic or permute produce zero

module fpu_perm_logic (
  input  fpu_pkg::fp_word_u opa,
  input  fpu_pkg::fp_word_u opb,
  input  fpu_pkg::op_t      perm_mode,
  output fpu_pkg::fp_word_u perm_res
);
  import fpu_pkg::*;

  always_comb begin
    perm_res = '0;
    case (perm_mode)
      OP_AND: begin
        perm_res = opa & opb;
      end
      OP_OR: begin
        perm_res = opa | opb;
      end
      OP_XOR: begin
        perm_res = opa ^ opb;
      end
      // a and not b
      OP_ANDN: begin
        perm_res = opa & ~opb;
      end
      OP_SWAP_S: begin
        perm_res.s[1] = opa.s[0];
        perm_res.s[0] = opa.s[1];
      end
      OP_DUP_LO: begin
        perm_res.s[1] = opa.s[0];
        perm_res.s[0] = opa.s[0];
      end
      default: begin
        perm_res = '0;
      end
    endcase
  end

endmodule

// ==== hdl/fpu_operand_sel.sv ====
// operand registers with forwarding of the unit's own result
// res is the value held just before the issue edge

module fpu_operand_sel (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid,
  input  fpu_pkg::fp_word_u a,
  input  fpu_pkg::fp_word_u b,
  input  fpu_pkg::fp_word_u res,
  input  logic             fwd_a,
  input  logic             fwd_b,
  output fpu_pkg::fp_word_u opa,
  output fpu_pkg::fp_word_u opb
);
  import fpu_pkg::*;

  always_ff @(posedge clk) begin
    if (rst) begin
      opa <= '0;
      opb <= '0;
    end else if (in_valid) begin
      // forward bit picks last result over the port
      opa <= fwd_a ? res : a;
      opb <= fwd_b ? res : b;
    end
  end

endmodule

// ==== hdl/fpu_op_decode.sv ====
// opcode and enable capture for the FP side unit
// one issue per strobe cycle, no back-pressure
// lane controls are decoded from the registered opcode

module fpu_op_decode (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        in_valid,
  input  fpu_pkg::op_t                op,
  input  logic [fpu_pkg::FPCSR_W-1:0] fpcsr,
  output logic                        issue_valid,
  output fpu_pkg::lane_t              lane,
  output fpu_pkg::op_t                perm_mode,
  output logic                        cmp_lt,
  output logic                        cmp_paired,
  output logic [1:0]                  exc_en
);
  import fpu_pkg::*;

  op_t op_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      issue_valid <= 1'b0;
      op_q        <= OP_AND;
      exc_en      <= 2'b00;
    end else begin
      issue_valid <= in_valid;
      // opcode and enables travel together with the strobe
      if (in_valid) begin
        op_q   <= op;
        exc_en <= {fpcsr[FPCSR_DEN_EN], fpcsr[FPCSR_INV_EN]};
      end
    end
  end

  always_comb begin
    lane       = LANE_NONE;
    cmp_lt     = 1'b0;
    cmp_paired = 1'b0;
    case (op_q)
      OP_AND, OP_OR, OP_XOR, OP_ANDN, OP_SWAP_S, OP_DUP_LO: begin
        lane = LANE_PERM;
      end
      OP_CMP_EQ_D: begin
        lane = LANE_CMP;
      end
      OP_CMP_LT_D: begin
        lane   = LANE_CMP;
        cmp_lt = 1'b1;
      end
      OP_CMP_EQ_PS: begin
        lane       = LANE_CMP;
        cmp_paired = 1'b1;
      end
      OP_CMP_LT_PS: begin
        lane       = LANE_CMP;
        cmp_lt     = 1'b1;
        cmp_paired = 1'b1;
      end
      default: begin
        lane = LANE_NONE;
      end
    endcase
  end

  // perm lane sorts out its own sub-operation
  assign perm_mode = op_q;

endmodule

// ==== hdl/fpu_pkg.sv ====
// shared types and constants for the packed FP side unit
// a word is read as one double or as two singles, single 0 in the low half
// opcodes outside the listed set give a zero result and no exception
// only the two low enable bits of the control register are used

package fpu_pkg;

  typedef struct packed {
    logic        sign;
    logic [10:0] exp;
    logic [51:0] man;
  } dbl_t;

  typedef struct packed {
    logic        sign;
    logic [7:0]  exp;
    logic [22:0] man;
  } sgl_t;

  // same 64 bits, two decodes
  typedef union packed {
    dbl_t           d;
    sgl_t [1:0]     s;
  } fp_word_u;

  typedef logic [3:0] op_t;

  localparam op_t OP_AND       = 4'h0;
  localparam op_t OP_OR        = 4'h1;
  localparam op_t OP_XOR       = 4'h2;
  localparam op_t OP_ANDN      = 4'h3;
  localparam op_t OP_SWAP_S    = 4'h4;
  localparam op_t OP_DUP_LO    = 4'h5;
  localparam op_t OP_CMP_EQ_D  = 4'h8;
  localparam op_t OP_CMP_LT_D  = 4'h9;
  localparam op_t OP_CMP_EQ_PS = 4'ha;
  localparam op_t OP_CMP_LT_PS = 4'hb;

  typedef logic [1:0] lane_t;

  localparam lane_t LANE_NONE = 2'd0;
  localparam lane_t LANE_PERM = 2'd1;
  localparam lane_t LANE_CMP  = 2'd2;

  typedef logic [1:0] exc_code_t;

  localparam exc_code_t EXC_NONE    = 2'd0;
  localparam exc_code_t EXC_INVALID = 2'd1;
  localparam exc_code_t EXC_DENORM  = 2'd2;

  localparam int FPCSR_W      = 8;
  localparam int FPCSR_INV_EN = 0;
  localparam int FPCSR_DEN_EN = 1;

  // magnitude limits, exponent and mantissa as one unsigned field
  localparam logic [62:0] DBL_INF_MAG  = 63'h7ff0_0000_0000_0000;
  localparam logic [62:0] DBL_MIN_NORM = 63'h0010_0000_0000_0000;
  localparam logic [62:0] SGL_INF_MAG  = 63'h0000_0000_7f80_0000;
  localparam logic [62:0] SGL_MIN_NORM = 63'h0000_0000_0080_0000;
  localparam int          DBL_QBIT     = 51;
  localparam int          SGL_QBIT     = 22;

endpackage
